// File: fetch_stimulus.txt
# L word_index(hex) word(hex) | E pc(hex) inst(hex) err | S stall_cycles(decimal)
# E records list the retire order; S records are stall bursts with random gaps between them.
L 00 00000013
L 01 0100006f
L 02 deadbeef
L 03 00100093
L 04 00c0006f
L 05 00200113
L 06 ff5ff06f
L 07 00300193
L 08 4000006f
# Forward over the filler word, back by 12, then forward again.
E 00000000 00000013 0
E 00000004 0100006f 0
E 00000014 00200113 0
E 00000018 ff5ff06f 0
E 0000000c 00100093 0
E 00000010 00c0006f 0
E 0000001c 00300193 0
E 00000020 4000006f 0
# Jump past the end of the SRAM, then the next address after it.
E 00000420 00000000 1
E 00000424 00000000 1
S 3
S 6
S 2
S 9
S 4

// File: build.f
fetch_pkg.sv
isram_rd_if.sv
ifu.sv
isram.sv
exu.sv
fetch_top.sv
tb_fetch.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the fetch front-end testbench with Verilator, runs it and checks the result.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 --top-module tb_fetch -f build.f; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/Vtb_fetch)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "TEST PASS"; then
	exit 0
fi
exit 1

// File: tb_fetch.sv
// Self-checking testbench for the fetch front end; loads the program in reset, checks retirements.
`timescale 1ns/10ps
module tb_fetch;
	import fetch_pkg::*;

	localparam int reset_cycles = 10;
	localparam int cycles_per_record = 40;
	localparam int timeout_margin = 200;

	logic                clk = 1'b0;
	logic                rst;
	logic                load_en;
	logic [isram_aw-1:0] load_addr;
	logic [xlen-1:0]     load_data;
	logic                retire_stall;
	logic                retire_valid;
	logic [xlen-1:0]     retire_pc;
	logic [xlen-1:0]     retire_inst;
	logic                retire_err;

	logic [isram_aw-1:0] prog_idx[$];
	logic [xlen-1:0]     prog_word[$];
	logic [xlen-1:0]     exp_pc[$];
	logic [xlen-1:0]     exp_inst[$];
	logic                exp_err[$];
	int                  stall_bursts[$];
	int                  total_stall;
	int                  burst_left;
	int                  gap_left;
	int                  record_no;
	int                  cycles;
	int                  limit;
	logic                held;   // Record was stalled at the last edge.

	fetch_top uut (
		.clk          (clk),
		.rst          (rst),
		.load_en      (load_en),
		.load_addr    (load_addr),
		.load_data    (load_data),
		.retire_stall (retire_stall),
		.retire_valid (retire_valid),
		.retire_pc    (retire_pc),
		.retire_inst  (retire_inst),
		.retire_err   (retire_err)
	);

	always #5 clk = ~clk;   // 10 ns period.

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("TEST FAIL");
		$fatal(1, "stopped at first error");
	endtask

	// Records are L (load), E (expected retire) and S (stall burst); # starts a comment line.
	task automatic read_stimulus();
		int              fd;
		int              c;
		int              n;
		int              s;
		logic [7:0]      ch;
		logic [xlen-1:0] a;
		logic [xlen-1:0] b;
		logic [xlen-1:0] e;
		fd = $fopen("fetch_stimulus.txt", "r");
		if (fd == 0)
			stop_run("cannot open fetch_stimulus.txt");
		c = $fgetc(fd);
		while (c != -1) begin
			ch = c[7:0];
			if (ch == "#") begin
				while (c != -1 && c[7:0] != "\n")
					c = $fgetc(fd);
			end else if (ch == "L") begin
				n = $fscanf(fd, "%h %h", a, b);
				if (n != 2)
					stop_run("malformed load record in stimulus file");
				prog_idx.push_back(a[isram_aw-1:0]);
				prog_word.push_back(b);
			end else if (ch == "E") begin
				n = $fscanf(fd, "%h %h %h", a, b, e);
				if (n != 3)
					stop_run("malformed expected record in stimulus file");
				exp_pc.push_back(a);
				exp_inst.push_back(b);
				exp_err.push_back(e[0]);
			end else if (ch == "S") begin
				n = $fscanf(fd, "%d", s);
				if (n != 1)
					stop_run("malformed stall record in stimulus file");
				stall_bursts.push_back(s);
				total_stall += s;
			end else if (ch != " " && ch != "\n" && ch != "\r" && ch != "\t") begin
				stop_run($sformatf("unknown record type %c in stimulus file", ch));
			end
			c = $fgetc(fd);
		end
		$fclose(fd);
	endtask

	// Random gap first, then the next burst from the file.
	task automatic drive_stall();
		if (gap_left == 0 && burst_left == 0 && stall_bursts.size() > 0) begin
			gap_left = 1 + int'($urandom % 6);
			burst_left = stall_bursts.pop_front();
		end
		if (gap_left > 0) begin
			retire_stall = 1'b0;
			gap_left--;
		end else if (burst_left > 0) begin
			retire_stall = 1'b1;
			burst_left--;
		end else begin
			retire_stall = 1'b0;
		end
	endtask

	// Sampled at the falling edge; the record retires on the next rising edge if not stalled.
	task automatic check_retire();
		if (held) begin
			assert (retire_valid === 1'b1)
			else stop_run("retire_valid dropped while the record was stalled");
		end
		held = 1'b0;
		if (retire_valid === 1'b1) begin
			assert (retire_pc === exp_pc[0] && retire_inst === exp_inst[0] &&
				retire_err === exp_err[0])
			else stop_run($sformatf(
				"mismatch %s_%0d: expected pc=%h inst=%h err=%b, actual pc=%h inst=%h err=%b",
				retire_stall ? "stall_hold" : "retire", record_no,
				exp_pc[0], exp_inst[0], exp_err[0],
				retire_pc, retire_inst, retire_err));
			if (retire_stall) begin
				held = 1'b1;
			end else begin
				void'(exp_pc.pop_front());
				void'(exp_inst.pop_front());
				void'(exp_err.pop_front());
				record_no++;
			end
		end
	endtask

	initial begin
		rst = 1'b1;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		retire_stall = 1'b0;
		held = 1'b0;
		burst_left = 0;
		gap_left = 0;
		record_no = 0;
		total_stall = 0;
		void'($urandom(47961));
		read_stimulus();
		if (prog_idx.size() >= reset_cycles)
			stop_run("program has more words than reset cycles to load them");
		if (exp_pc.size() == 0)
			stop_run("stimulus file holds no expected retire records");
		limit = exp_pc.size() * cycles_per_record + total_stall + timeout_margin;

		// One program word per cycle while reset is held.
		for (int i = 0; i < reset_cycles; i++) begin
			@(posedge clk);
			#1;
			if (i < prog_idx.size()) begin
				load_en = 1'b1;
				load_addr = prog_idx[i];
				load_data = prog_word[i];
			end else begin
				load_en = 1'b0;
			end
		end
		rst = 1'b0;

		@(negedge clk);
		assert (retire_valid === 1'b0)
		else stop_run("retire_valid is not low after reset");

		cycles = 0;
		while (exp_pc.size() > 0 && cycles < limit) begin
			@(posedge clk);
			#1;
			drive_stall();
			@(negedge clk);
			check_retire();
			cycles++;
		end

		if (exp_pc.size() == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("retirement stalled: %0d records still expected after %0d cycles",
				exp_pc.size(), cycles);
			$display("TEST FAIL");
			$fatal(1, "timeout");
		end
	end

endmodule

// File: fetch_top.sv
// Top level of the fetch front end; joins fetch unit, instruction SRAM and exu behind plain ports.
`timescale 1ns/10ps
module fetch_top (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           load_en,
	input  logic [fetch_pkg::isram_aw-1:0] load_addr,
	input  logic [fetch_pkg::xlen-1:0]     load_data,
	input  logic                           retire_stall,
	output logic                           retire_valid,
	output logic [fetch_pkg::xlen-1:0]     retire_pc,
	output logic [fetch_pkg::xlen-1:0]     retire_inst,
	output logic                           retire_err
);
	import fetch_pkg::*;

	ifu_to_exu_t ifu_to_exu;
	logic        ifu_to_exu_valid;
	exu_to_ifu_t exu_to_ifu;   // Jump redirect.
	logic        exu_to_ifu_valid;
	logic        exu_allowin;

	isram_rd_if isram_bus ();

	ifu u_ifu (
		.clk              (clk),
		.rst              (rst),
		.exu_to_ifu       (exu_to_ifu),
		.exu_to_ifu_valid (exu_to_ifu_valid),
		.exu_allowin      (exu_allowin),
		.ifu_to_exu       (ifu_to_exu),
		.ifu_to_exu_valid (ifu_to_exu_valid),
		.mem              (isram_bus.master)
	);

	isram u_isram (
		.clk       (clk),
		.rst       (rst),
		.load_en   (load_en),
		.load_addr (load_addr),
		.load_data (load_data),
		.port      (isram_bus.slave)
	);

	exu u_exu (
		.clk              (clk),
		.rst              (rst),
		.ifu_to_exu       (ifu_to_exu),
		.ifu_to_exu_valid (ifu_to_exu_valid),
		.retire_stall     (retire_stall),
		.exu_allowin      (exu_allowin),
		.exu_to_ifu       (exu_to_ifu),
		.exu_to_ifu_valid (exu_to_ifu_valid),
		.retire_valid     (retire_valid),
		.retire_pc        (retire_pc),
		.retire_inst      (retire_inst),
		.retire_err       (retire_err)
	);

endmodule

// File: exu.sv
// Decode/execute stage; holds one fetched word, resolves JAL and presents it as a retire record.
`timescale 1ns/10ps
module exu (
	input  logic                       clk,
	input  logic                       rst,
	input  fetch_pkg::ifu_to_exu_t     ifu_to_exu,
	input  logic                       ifu_to_exu_valid,
	input  logic                       retire_stall,
	output logic                       exu_allowin,
	output fetch_pkg::exu_to_ifu_t     exu_to_ifu,
	output logic                       exu_to_ifu_valid,
	output logic                       retire_valid,
	output logic [fetch_pkg::xlen-1:0] retire_pc,
	output logic [fetch_pkg::xlen-1:0] retire_inst,
	output logic                       retire_err
);
	import fetch_pkg::*;

	ifu_to_exu_t     pkt;
	logic            full;
	logic            is_jal;
	logic [xlen-1:0] imm_j;

	// Empty, or the held packet leaves this cycle.
	assign exu_allowin = !full || !retire_stall;

	always_ff @(posedge clk) begin
		if (rst)
			full <= 1'b0;
		else if (ifu_to_exu_valid)
			full <= 1'b1;
		else if (!retire_stall)
			full <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (ifu_to_exu_valid)
			pkt <= ifu_to_exu;
	end

	// A faulted fetch carries no real instruction.
	assign is_jal = (pkt.inst[6:0] == opcode_jal) && !pkt.err;

	// J-type immediate with bit 0 always zero.
	assign imm_j = {{11{pkt.inst[31]}}, pkt.inst[31], pkt.inst[19:12],
		pkt.inst[20], pkt.inst[30:21], 1'b0};

	assign exu_to_ifu = '{
		taken:  is_jal,
		target: pkt.pc + imm_j
	};
	assign exu_to_ifu_valid = full;

	assign retire_valid = full;
	assign retire_pc = pkt.pc;
	assign retire_inst = pkt.inst;
	assign retire_err = pkt.err;

	// Fetch must wait for room before finishing a read.
	a_no_overrun: assert property (@(posedge clk) disable iff (rst)
		ifu_to_exu_valid |-> !(full && retire_stall));

endmodule

// File: isram.sv
// Instruction SRAM model; loaded during reset, answers reads with random wait states.
`timescale 1ns/10ps
module isram (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           load_en,
	input  logic [fetch_pkg::isram_aw-1:0] load_addr,
	input  logic [fetch_pkg::xlen-1:0]     load_data,
	isram_rd_if.slave                      port
);
	import fetch_pkg::*;

	typedef enum logic [2:0] {
		s_idle,
		s_ar_wait,
		s_ar_hs,
		s_r_wait,
		s_r_hs
	} sram_state_t;

	logic [xlen-1:0] mem [isram_words];
	sram_state_t     state;
	logic [7:0]      lfsr;
	logic [1:0]      wait_cnt;
	logic            arready_r;
	logic            rvalid_r;
	logic [xlen-1:0] rdata_r;
	logic [1:0]      rresp_r;
	logic            in_range;
	logic            outstanding;

	assign in_range = port.araddr < xlen'(isram_words * 4);

	// Program image only goes in while reset is held.
	always_ff @(posedge clk) begin
		if (rst && load_en)
			mem[load_addr] <= load_data;
	end

	// x^8 + x^6 + x^5 + x^4 + 1.
	always_ff @(posedge clk) begin
		if (rst)
			lfsr <= 8'hb5;
		else
			lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= s_idle;
			arready_r <= 1'b0;
			rvalid_r <= 1'b0;
			wait_cnt <= 2'd0;
		end else begin
			case (state)
				s_idle:
					if (port.arvalid) begin
						if (lfsr[1:0] == 2'd0) begin
							arready_r <= 1'b1;
							state <= s_ar_hs;
						end else begin
							wait_cnt <= lfsr[1:0] - 2'd1;
							state <= s_ar_wait;
						end
					end
				s_ar_wait:
					if (wait_cnt == 2'd0) begin
						arready_r <= 1'b1;
						state <= s_ar_hs;
					end else begin
						wait_cnt <= wait_cnt - 2'd1;
					end
				s_ar_hs:
					if (port.arvalid) begin   // Address taken this cycle.
						arready_r <= 1'b0;
						if (lfsr[3:2] == 2'd0) begin
							rvalid_r <= 1'b1;
							state <= s_r_hs;
						end else begin
							wait_cnt <= lfsr[3:2] - 2'd1;
							state <= s_r_wait;
						end
					end
				s_r_wait:
					if (wait_cnt == 2'd0) begin
						rvalid_r <= 1'b1;
						state <= s_r_hs;
					end else begin
						wait_cnt <= wait_cnt - 2'd1;
					end
				s_r_hs:
					if (port.rready) begin
						rvalid_r <= 1'b0;
						state <= s_idle;
					end
				default:
					state <= s_idle;
			endcase
		end
	end

	// Read data sampled at address acceptance.
	always_ff @(posedge clk) begin
		if (port.arvalid && port.arready) begin
			if (in_range) begin
				rdata_r <= mem[port.araddr[isram_aw+1:2]];
				rresp_r <= resp_okay;
			end else begin
				rdata_r <= '0;
				rresp_r <= resp_slverr;   // Past the end of the array.
			end
		end
	end

	// Tracks accepted but unanswered reads from the bus side.
	always_ff @(posedge clk) begin
		if (rst)
			outstanding <= 1'b0;
		else if (port.arvalid && port.arready)
			outstanding <= 1'b1;
		else if (port.rvalid && port.rready)
			outstanding <= 1'b0;
	end

	assign port.arready = arready_r;
	assign port.rvalid = rvalid_r;
	assign port.rdata = rdata_r;
	assign port.rresp = rresp_r;

	a_rvalid_owed: assert property (@(posedge clk) disable iff (rst)
		port.rvalid |-> outstanding);

endmodule

// File: ifu.sv
// Fetch unit; keeps the pc, reads one word at a time from the SRAM and passes it to the exu.
`timescale 1ns/10ps
module ifu (
	input  logic                   clk,
	input  logic                   rst,
	input  fetch_pkg::exu_to_ifu_t exu_to_ifu,
	input  logic                   exu_to_ifu_valid,
	input  logic                   exu_allowin,
	output fetch_pkg::ifu_to_exu_t ifu_to_exu,
	output logic                   ifu_to_exu_valid,
	isram_rd_if.master             mem
);
	import fetch_pkg::*;

	typedef enum logic [2:0] {
		idle_r,
		wait_arready,
		shaked_ar,
		wait_rvalid,
		shaked_r
	} rd_state_t;

	rd_state_t       state;
	rd_state_t       next_state;
	logic [xlen-1:0] pc;            // Address of the word in flight.
	logic [xlen-1:0] next_pc;
	logic [xlen-1:0] araddr_r;
	logic            arvalid_r;
	logic            rready_r;
	logic            first_fetch;
	logic            ifu_allowin;
	logic            ar_hs;
	logic            r_hs;

	assign ar_hs = mem.arvalid && mem.arready;
	assign r_hs = mem.rvalid && mem.rready;

	// Nothing in flight and the exu can take the next word.
	assign ifu_allowin = exu_allowin && (state == idle_r || state == shaked_r);

	always_comb begin
		if (first_fetch)
			next_pc = reset_pc;
		else if (exu_to_ifu_valid && exu_to_ifu.taken)
			next_pc = exu_to_ifu.target;   // Jump resolved in the exu.
		else
			next_pc = pc + xlen'(4);
	end

	always_comb begin
		next_state = state;
		case (state)
			idle_r, shaked_r:
				next_state = ifu_allowin ? wait_arready : idle_r;
			wait_arready:
				if (ar_hs)
					next_state = shaked_ar;
			shaked_ar:
				next_state = r_hs ? shaked_r : wait_rvalid;
			wait_rvalid:
				if (r_hs)
					next_state = shaked_r;
			default:
				next_state = idle_r;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= idle_r;
			arvalid_r <= 1'b0;
			rready_r <= 1'b0;
			first_fetch <= 1'b1;
		end else begin
			state <= next_state;
			arvalid_r <= (next_state == wait_arready);
			rready_r <= (next_state == shaked_ar || next_state == wait_rvalid);
			if (ifu_allowin)
				first_fetch <= 1'b0;
		end
	end

	// Address is captured at launch and held until accepted.
	always_ff @(posedge clk) begin
		if (ifu_allowin)
			araddr_r <= next_pc;
		if (ar_hs)
			pc <= mem.araddr;   // Pc register follows the accepted address.
	end

	assign mem.araddr = araddr_r;
	assign mem.arvalid = arvalid_r;
	assign mem.rready = rready_r;

	// Word goes straight through on the response handshake.
	assign ifu_to_exu = '{
		pc:   pc,
		inst: mem.rdata,
		err:  (mem.rresp != resp_okay)
	};
	assign ifu_to_exu_valid = r_hs;

	// The request holds still while the slave stretches arready.
	a_araddr_stable: assert property (@(posedge clk) disable iff (rst)
		mem.arvalid && !mem.arready |=> $stable(mem.araddr));

	a_valid_pulse: assert property (@(posedge clk) disable iff (rst)
		ifu_to_exu_valid |=> !ifu_to_exu_valid);

endmodule

// File: isram_rd_if.sv
// Instruction SRAM read channel with address and response phases; fetch is master, SRAM is slave.
`timescale 1ns/10ps
interface isram_rd_if;
	import fetch_pkg::*;

	// Address phase.
	logic [xlen-1:0] araddr;
	logic            arvalid;
	logic            arready;

	// Response phase.
	logic [xlen-1:0] rdata;
	logic            rvalid;
	logic [1:0]      rresp;
	logic            rready;

	modport master (
		output araddr, arvalid, rready,
		input  arready, rdata, rvalid, rresp
	);

	modport slave (
		input  araddr, arvalid, rready,
		output arready, rdata, rvalid, rresp
	);

endinterface

// File: fetch_pkg.sv
// Widths, memory size, response codes, opcodes and packet types shared by every fetch RTL block.
package fetch_pkg;

	// Data and address width.
	localparam int xlen = 32;

	// First fetch address after reset.
	localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

	// SRAM depth in words and the matching word-index width.
	localparam int isram_words = 256;
	localparam int isram_aw = $clog2(isram_words);

	// Read response codes.
	localparam logic [1:0] resp_okay = 2'd0;
	localparam logic [1:0] resp_slverr = 2'd2;

	localparam logic [6:0] opcode_jal = 7'b1101111;

	// Fetched word on its way to the exu.
	typedef struct packed {
		logic [xlen-1:0] pc;
		logic [xlen-1:0] inst;
		logic            err;   // Bus error on the read.
	} ifu_to_exu_t;

	// Next-pc redirect back to the fetch unit.
	typedef struct packed {
		logic            taken;
		logic [xlen-1:0] target;
	} exu_to_ifu_t;

endpackage
